/* cache_macros.svh */
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// Data word
`define CACHE_WORD_BITS      32
`define CACHE_WORD_BYTES     4

// Cache geometry
`define CACHE_LINE_WORDS     4
`define CACHE_NUM_LINES      16

// Core side
`define CACHE_WORD_ADDR_BITS 12
`define CACHE_CORE_TAG_BITS  4

// Memory request queue entries
`define CACHE_MREQ_DEPTH     4

// Event counters
`define CACHE_PERF_BITS      16

`endif

/* cache_pkg.sv */
`include "cache_macros.svh"

package cache_pkg;

    typedef logic [`CACHE_WORD_BITS-1:0]  word_t;
    typedef logic [`CACHE_WORD_BYTES-1:0] byteen_t;
    typedef logic [`CACHE_WORD_ADDR_BITS-1:0] word_addr_t;

    // Word address is {cache_tag, index, wsel}
    typedef logic [$clog2(`CACHE_LINE_WORDS)-1:0] wsel_t;
    typedef logic [$clog2(`CACHE_NUM_LINES)-1:0]  index_t;
    typedef logic [`CACHE_WORD_ADDR_BITS-$clog2(`CACHE_NUM_LINES)
                   -$clog2(`CACHE_LINE_WORDS)-1:0] cache_tag_t;
    typedef logic [`CACHE_WORD_ADDR_BITS-$clog2(`CACHE_LINE_WORDS)-1:0] line_addr_t;

    typedef logic [`CACHE_LINE_WORDS*`CACHE_WORD_BITS-1:0]  line_t;
    typedef logic [`CACHE_LINE_WORDS*`CACHE_WORD_BYTES-1:0] line_byteen_t;

    typedef logic [`CACHE_CORE_TAG_BITS-1:0] core_tag_t;
    typedef logic [`CACHE_PERF_BITS-1:0]     perf_ctr_t;

    typedef enum logic {
        OP_READ,
        OP_WRITE
    } mem_op_e;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        FILL_REQ,
        FILL_WAIT,
        RESPOND
    } bank_state_e;

endpackage

/* mem_req_if.sv */
`timescale 1ns/1ps

interface mem_req_if import cache_pkg::*; ();

    logic         valid;
    mem_op_e      op;
    line_addr_t   addr;
    line_byteen_t byteen;
    line_t        data;
    logic         ready;

    modport bank (
        output valid, op, addr, byteen, data,
        input  ready
    );

    modport queue (
        input  valid, op, addr, byteen, data,
        output ready
    );

endinterface

/* flush_ctrl.sv */
`timescale 1ns/1ps
`include "cache_macros.svh"

module flush_ctrl import cache_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    output logic   flush_busy,
    output index_t flush_index
);

    // Walks every line once after reset, one index per cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            flush_busy  <= 1'b1;
            flush_index <= '0;
        end else if (flush_busy) begin
            if (flush_index == index_t'(`CACHE_NUM_LINES - 1)) begin
                flush_busy <= 1'b0;
            end
            flush_index <= flush_index + 1'b1;
        end
    end

endmodule

/* cache_tag_ram.sv */
`timescale 1ns/1ps
`include "cache_macros.svh"

module cache_tag_ram import cache_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  index_t     lookup_index,
    input  cache_tag_t lookup_tag,
    input  logic       wr_en,
    input  index_t     wr_index,
    input  cache_tag_t wr_tag,
    input  logic       wr_valid,
    output logic       hit
);

    cache_tag_t tags   [`CACHE_NUM_LINES];
    logic       valids [`CACHE_NUM_LINES];

    // Single write port, shared by flush and fill
    always_ff @(posedge clk) begin
        if (wr_en) begin
            tags[wr_index]   <= wr_tag;
            valids[wr_index] <= wr_valid;
        end
    end

    // Hit is seen one cycle after the lookup
    always_ff @(posedge clk) begin
        if (reset) begin
            hit <= 1'b0;
        end else begin
            hit <= valids[lookup_index] && (tags[lookup_index] == lookup_tag);
        end
    end

endmodule

/* cache_data_ram.sv */
`timescale 1ns/1ps
`include "cache_macros.svh"

module cache_data_ram import cache_pkg::*; (
    input  logic    clk,
    input  index_t  rd_index,
    input  wsel_t   rd_wsel,
    input  logic    word_wr_en,
    input  index_t  wr_index,
    input  wsel_t   wr_wsel,
    input  byteen_t wr_byteen,
    input  word_t   wr_word,
    input  logic    fill_en,
    input  line_t   fill_line,
    output word_t   rd_word
);

    word_t lines [`CACHE_NUM_LINES][`CACHE_LINE_WORDS];

    always_ff @(posedge clk) begin
        if (fill_en) begin
            for (int w = 0; w < `CACHE_LINE_WORDS; w++) begin
                lines[wr_index][w] <= fill_line[w*`CACHE_WORD_BITS +: `CACHE_WORD_BITS];
            end
        end else if (word_wr_en) begin
            // Only the enabled bytes change
            for (int b = 0; b < `CACHE_WORD_BYTES; b++) begin
                if (wr_byteen[b]) begin
                    lines[wr_index][wr_wsel][b*8 +: 8] <= wr_word[b*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        rd_word <= lines[rd_index][rd_wsel];
    end

endmodule

/* mem_req_queue.sv */
`timescale 1ns/1ps
`include "cache_macros.svh"

module mem_req_queue import cache_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    mem_req_if.queue     in_req,
    output logic         mem_req_valid,
    output mem_op_e      mem_req_op,
    output line_addr_t   mem_req_addr,
    output line_byteen_t mem_req_byteen,
    output line_t        mem_req_data,
    input  logic         mem_req_ready
);

    localparam int PTR_BITS = $clog2(`CACHE_MREQ_DEPTH);

    mem_op_e      op_q     [`CACHE_MREQ_DEPTH];
    line_addr_t   addr_q   [`CACHE_MREQ_DEPTH];
    line_byteen_t byteen_q [`CACHE_MREQ_DEPTH];
    line_t        data_q   [`CACHE_MREQ_DEPTH];

    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [$clog2(`CACHE_MREQ_DEPTH+1)-1:0] count;

    logic full;
    logic empty;
    logic push;
    logic pop;

    assign full  = (count == `CACHE_MREQ_DEPTH);
    assign empty = (count == 0);
    assign push  = in_req.valid && in_req.ready;
    assign pop   = mem_req_valid && mem_req_ready;

    assign in_req.ready = !full;

    always_ff @(posedge clk) begin
        if (push) begin
            op_q[wr_ptr]     <= in_req.op;
            addr_q[wr_ptr]   <= in_req.addr;
            byteen_q[wr_ptr] <= in_req.byteen;
            data_q[wr_ptr]   <= in_req.data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    // Head entry goes straight to memory
    assign mem_req_valid  = !empty;
    assign mem_req_op     = op_q[rd_ptr];
    assign mem_req_addr   = addr_q[rd_ptr];
    assign mem_req_byteen = byteen_q[rd_ptr];
    assign mem_req_data   = data_q[rd_ptr];

endmodule

/* cache_bank.sv */
`timescale 1ns/1ps
`include "cache_macros.svh"

module cache_bank import cache_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       flush_busy,
    input  index_t     flush_index,

    input  logic       core_req_valid,
    input  mem_op_e    core_req_op,
    input  word_addr_t core_req_addr,
    input  byteen_t    core_req_byteen,
    input  word_t      core_req_data,
    input  core_tag_t  core_req_tag,
    output logic       core_req_ready,

    output logic       core_rsp_valid,
    output word_t      core_rsp_data,
    output core_tag_t  core_rsp_tag,
    input  logic       core_rsp_ready,

    mem_req_if.bank    mem_req,

    input  logic       mem_rsp_valid,
    input  line_t      mem_rsp_data,
    output logic       mem_rsp_ready,

    output logic       perf_read,
    output logic       perf_write,
    output logic       perf_read_miss
);

    bank_state_e state;
    bank_state_e state_n;

    // Accepted request
    mem_op_e    req_op;
    word_addr_t req_addr;
    byteen_t    req_byteen;
    word_t      req_data;
    core_tag_t  req_tag;
    word_t      rsp_data;

    cache_tag_t core_ctag;
    index_t     core_index;
    wsel_t      core_wsel;
    cache_tag_t req_ctag;
    index_t     req_index;
    wsel_t      req_wsel;

    logic  accept;
    logic  hit;
    logic  fill_en;
    word_t rd_word;

    assign {core_ctag, core_index, core_wsel} = core_req_addr;
    assign {req_ctag, req_index, req_wsel}    = req_addr;

    assign core_req_ready = (state == IDLE) && !flush_busy;
    assign accept         = core_req_valid && core_req_ready;
    assign fill_en        = (state == FILL_WAIT) && mem_rsp_valid;

    ////////////////////////////////////////
    // Tag and data storage

    // Lookups follow the core address so the hit is ready in LOOKUP
    cache_tag_ram tag_ram (
        .clk          (clk),
        .reset        (reset),
        .lookup_index (core_index),
        .lookup_tag   (core_ctag),
        .wr_en        (flush_busy || fill_en),
        .wr_index     (flush_busy ? flush_index : req_index),
        .wr_tag       (req_ctag),
        .wr_valid     (!flush_busy),
        .hit          (hit)
    );

    cache_data_ram data_ram (
        .clk        (clk),
        .rd_index   (core_index),
        .rd_wsel    (core_wsel),
        .word_wr_en ((state == LOOKUP) && (req_op == OP_WRITE) && hit),
        .wr_index   (req_index),
        .wr_wsel    (req_wsel),
        .wr_byteen  (req_byteen),
        .wr_word    (req_data),
        .fill_en    (fill_en),
        .fill_line  (mem_rsp_data),
        .rd_word    (rd_word)
    );

    ////////////////////////////////////////
    // FSM

    always_comb begin
        state_n = state;
        case (state)
            IDLE:      if (accept) state_n = LOOKUP;
            LOOKUP:    state_n = (req_op == OP_READ && hit) ? RESPOND : FILL_REQ;
            FILL_REQ: begin
                if (mem_req.ready) begin
                    state_n = (req_op == OP_WRITE) ? IDLE : FILL_WAIT;
                end
            end
            FILL_WAIT: if (mem_rsp_valid) state_n = RESPOND;
            RESPOND:   if (core_rsp_ready) state_n = IDLE;
            default:   state_n = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= state_n;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_op     <= core_req_op;
            req_addr   <= core_req_addr;
            req_byteen <= core_req_byteen;
            req_data   <= core_req_data;
            req_tag    <= core_req_tag;
        end
        if (state == LOOKUP) begin
            rsp_data <= rd_word;
        end else if (fill_en) begin
            rsp_data <= mem_rsp_data[req_wsel*`CACHE_WORD_BITS +: `CACHE_WORD_BITS];
        end
    end

    assign core_rsp_valid = (state == RESPOND);
    assign core_rsp_data  = rsp_data;
    assign core_rsp_tag   = req_tag;
    assign mem_rsp_ready  = (state == FILL_WAIT);

    ////////////////////////////////////////
    // Memory request

    assign mem_req.valid = (state == FILL_REQ);
    assign mem_req.op    = req_op;
    assign mem_req.addr  = {req_ctag, req_index};

    // Write data and enables sit at the selected word only
    always_comb begin
        mem_req.byteen = '0;
        mem_req.data   = '0;
        if (req_op == OP_WRITE) begin
            mem_req.byteen[req_wsel*`CACHE_WORD_BYTES +: `CACHE_WORD_BYTES] = req_byteen;
            mem_req.data[req_wsel*`CACHE_WORD_BITS +: `CACHE_WORD_BITS]    = req_data;
        end
    end

    assign perf_read      = accept && (core_req_op == OP_READ);
    assign perf_write     = accept && (core_req_op == OP_WRITE);
    assign perf_read_miss = (state == LOOKUP) && (req_op == OP_READ) && !hit;

endmodule

/* perf_counters.sv */
`timescale 1ns/1ps

module perf_counters import cache_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      perf_read,
    input  logic      perf_write,
    input  logic      perf_read_miss,
    input  logic      mem_req_valid,
    input  logic      mem_req_ready,
    output perf_ctr_t perf_reads,
    output perf_ctr_t perf_writes,
    output perf_ctr_t perf_read_misses,
    output perf_ctr_t perf_mem_stalls
);

    // Counters wrap on overflow
    always_ff @(posedge clk) begin
        if (reset) begin
            perf_reads       <= '0;
            perf_writes      <= '0;
            perf_read_misses <= '0;
            perf_mem_stalls  <= '0;
        end else begin
            perf_reads       <= perf_reads + perf_ctr_t'(perf_read);
            perf_writes      <= perf_writes + perf_ctr_t'(perf_write);
            perf_read_misses <= perf_read_misses + perf_ctr_t'(perf_read_miss);
            // Memory held the request off this cycle
            perf_mem_stalls  <= perf_mem_stalls + perf_ctr_t'(mem_req_valid && !mem_req_ready);
        end
    end

endmodule

/* cache_top.sv */
`timescale 1ns/1ps

module cache_top import cache_pkg::*; (
    input  logic         clk,
    input  logic         reset,

    input  logic         core_req_valid,
    input  mem_op_e      core_req_op,
    input  word_addr_t   core_req_addr,
    input  byteen_t      core_req_byteen,
    input  word_t        core_req_data,
    input  core_tag_t    core_req_tag,
    output logic         core_req_ready,

    output logic         core_rsp_valid,
    output word_t        core_rsp_data,
    output core_tag_t    core_rsp_tag,
    input  logic         core_rsp_ready,

    output logic         mem_req_valid,
    output mem_op_e      mem_req_op,
    output line_addr_t   mem_req_addr,
    output line_byteen_t mem_req_byteen,
    output line_t        mem_req_data,
    input  logic         mem_req_ready,

    input  logic         mem_rsp_valid,
    input  line_t        mem_rsp_data,
    output logic         mem_rsp_ready,

    output perf_ctr_t    perf_reads,
    output perf_ctr_t    perf_writes,
    output perf_ctr_t    perf_read_misses,
    output perf_ctr_t    perf_mem_stalls
);

    logic   flush_busy;
    index_t flush_index;
    logic   perf_read;
    logic   perf_write;
    logic   perf_read_miss;

    mem_req_if mem_req_bus ();

    flush_ctrl flush0 (
        .clk         (clk),
        .reset       (reset),
        .flush_busy  (flush_busy),
        .flush_index (flush_index)
    );

    cache_bank bank0 (
        .clk             (clk),
        .reset           (reset),
        .flush_busy      (flush_busy),
        .flush_index     (flush_index),
        .core_req_valid  (core_req_valid),
        .core_req_op     (core_req_op),
        .core_req_addr   (core_req_addr),
        .core_req_byteen (core_req_byteen),
        .core_req_data   (core_req_data),
        .core_req_tag    (core_req_tag),
        .core_req_ready  (core_req_ready),
        .core_rsp_valid  (core_rsp_valid),
        .core_rsp_data   (core_rsp_data),
        .core_rsp_tag    (core_rsp_tag),
        .core_rsp_ready  (core_rsp_ready),
        .mem_req         (mem_req_bus.bank),
        .mem_rsp_valid   (mem_rsp_valid),
        .mem_rsp_data    (mem_rsp_data),
        .mem_rsp_ready   (mem_rsp_ready),
        .perf_read       (perf_read),
        .perf_write      (perf_write),
        .perf_read_miss  (perf_read_miss)
    );

    mem_req_queue mreq_queue0 (
        .clk            (clk),
        .reset          (reset),
        .in_req         (mem_req_bus.queue),
        .mem_req_valid  (mem_req_valid),
        .mem_req_op     (mem_req_op),
        .mem_req_addr   (mem_req_addr),
        .mem_req_byteen (mem_req_byteen),
        .mem_req_data   (mem_req_data),
        .mem_req_ready  (mem_req_ready)
    );

    perf_counters perf0 (
        .clk              (clk),
        .reset            (reset),
        .perf_read        (perf_read),
        .perf_write       (perf_write),
        .perf_read_miss   (perf_read_miss),
        .mem_req_valid    (mem_req_valid),
        .mem_req_ready    (mem_req_ready),
        .perf_reads       (perf_reads),
        .perf_writes      (perf_writes),
        .perf_read_misses (perf_read_misses),
        .perf_mem_stalls  (perf_mem_stalls)
    );

endmodule

/* tb_cache_chk.sv */
`timescale 1ns/1ps
`include "cache_macros.svh"

module tb_cache_chk import cache_pkg::*; (
    input logic         clk,
    input logic         reset,
    input logic         core_req_valid,
    input mem_op_e      core_req_op,
    input core_tag_t    core_req_tag,
    input logic         core_req_ready,
    input logic         core_rsp_valid,
    input word_t        core_rsp_data,
    input core_tag_t    core_rsp_tag,
    input logic         core_rsp_ready,
    input logic         mem_req_valid,
    input mem_op_e      mem_req_op,
    input line_addr_t   mem_req_addr,
    input line_byteen_t mem_req_byteen,
    input line_t        mem_req_data,
    input logic         mem_req_ready
);

    logic [4:0] since_reset;
    core_tag_t  last_read_tag;
    int         fail_count = 0;

    always_ff @(posedge clk) begin
        if (reset) begin
            since_reset <= '0;
        end else if (since_reset != 5'(`CACHE_NUM_LINES)) begin
            since_reset <= since_reset + 1'b1;
        end
        if (core_req_valid && core_req_ready && core_req_op == OP_READ) begin
            last_read_tag <= core_req_tag;
        end
    end

    core_rsp_stable: assert property (@(posedge clk) disable iff (reset)
        core_rsp_valid && !core_rsp_ready |=>
            core_rsp_valid && $stable(core_rsp_data) && $stable(core_rsp_tag))
        else begin
            fail_count++;
            $error("core response changed while stalled");
        end

    mem_req_stable: assert property (@(posedge clk) disable iff (reset)
        mem_req_valid && !mem_req_ready |=>
            mem_req_valid && $stable(mem_req_op) && $stable(mem_req_addr)
            && $stable(mem_req_byteen) && $stable(mem_req_data))
        else begin
            fail_count++;
            $error("memory request changed while stalled");
        end

    // No core request while the flush walks the lines
    no_accept_in_flush: assert property (@(posedge clk) disable iff (reset)
        (since_reset < 5'(`CACHE_NUM_LINES)) |-> !core_req_ready)
        else begin
            fail_count++;
            $error("core_req_ready high during flush");
        end

    rsp_tag_matches: assert property (@(posedge clk) disable iff (reset)
        core_rsp_valid |-> core_rsp_tag == last_read_tag)
        else begin
            fail_count++;
            $error("response tag differs from last accepted read");
        end

endmodule

/* tb_cache.sv */
`timescale 1ns/1ps
`include "cache_macros.svh"

module tb_cache import cache_pkg::*; ();

    localparam int N_OPS          = 400;
    localparam int N_DIRECTED     = 9;
    localparam int TIMEOUT_CYCLES = (N_OPS + N_DIRECTED) * 64 + 100;

    typedef struct packed {
        mem_op_e      op;
        line_addr_t   addr;
        line_byteen_t be;
        wsel_t        wsel;
        word_t        word;
    } mreq_exp_t;

    typedef struct packed {
        core_tag_t tag;
        word_t     data;
        logic      hit;
        int        cycle;
    } rsp_exp_t;

    logic         clk = 1'b0;
    logic         reset;
    logic         core_req_valid;
    mem_op_e      core_req_op;
    word_addr_t   core_req_addr;
    byteen_t      core_req_byteen;
    word_t        core_req_data;
    core_tag_t    core_req_tag;
    logic         core_req_ready;
    logic         core_rsp_valid;
    word_t        core_rsp_data;
    core_tag_t    core_rsp_tag;
    logic         core_rsp_ready;
    logic         mem_req_valid;
    mem_op_e      mem_req_op;
    line_addr_t   mem_req_addr;
    line_byteen_t mem_req_byteen;
    line_t        mem_req_data;
    logic         mem_req_ready;
    logic         mem_rsp_valid;
    line_t        mem_rsp_data;
    logic         mem_rsp_ready;
    perf_ctr_t    perf_reads;
    perf_ctr_t    perf_writes;
    perf_ctr_t    perf_read_misses;
    perf_ctr_t    perf_mem_stalls;

    logic [31:0] lfsr_state = 32'h6bf0823c;
    string       test_name = "reset";
    logic        random_ready = 1'b0;
    core_tag_t   next_tag = '0;
    int          cycle = 0;
    int          n_reads = 0;
    int          n_writes = 0;
    int          n_misses = 0;
    int          n_stalls = 0;
    int          rsp_wait = 0;
    logic        rsp_seen = 1'b0;

    word_t      mem_words [1 << `CACHE_WORD_ADDR_BITS];
    word_t      shadow    [1 << `CACHE_WORD_ADDR_BITS];
    logic       model_valid [`CACHE_NUM_LINES];
    cache_tag_t model_tag   [`CACHE_NUM_LINES];
    mreq_exp_t  exp_mreq [$];
    rsp_exp_t   exp_rsp  [$];
    line_addr_t rd_pending [$];

    cache_top dut0 (.*);

    bind cache_top tb_cache_chk chk0 (.*);

    always #50 clk = ~clk;

    ////////////////////////////////////////
    // Helpers

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic word_t fill_pattern(input word_addr_t a);
        return {4'hc, a, 4'h3, ~a};
    endfunction

    function automatic word_t merge_bytes(input word_t old, input word_t data, input byteen_t be);
        word_t r;
        r = old;
        for (int b = 0; b < `CACHE_WORD_BYTES; b++) begin
            if (be[b]) begin
                r[b*8 +: 8] = data[b*8 +: 8];
            end
        end
        return r;
    endfunction

    // Expected read data
    function automatic word_t ref_read(input word_addr_t a);
        return shadow[a];
    endfunction

    task automatic halt_with_failure();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic abort_run(input string msg);
        $display("%s (test %s)", msg, test_name);
        halt_with_failure();
    endtask

    task automatic check_word(input string what, input word_t exp, input word_t act);
        if (exp !== act) begin
            $display("ERR %s %s: expected %h actual %h", test_name, what, exp, act);
            halt_with_failure();
        end
    endtask

    task automatic check_tag(input string what, input core_tag_t exp, input core_tag_t act);
        if (exp !== act) begin
            $display("ERR %s %s: expected %h actual %h", test_name, what, exp, act);
            halt_with_failure();
        end
    endtask

    task automatic check_line_addr(input string what, input line_addr_t exp,
                                   input line_addr_t act);
        if (exp !== act) begin
            $display("ERR %s %s: expected %h actual %h", test_name, what, exp, act);
            halt_with_failure();
        end
    endtask

    task automatic check_byteen(input string what, input line_byteen_t exp,
                                input line_byteen_t act);
        if (exp !== act) begin
            $display("ERR %s %s: expected %h actual %h", test_name, what, exp, act);
            halt_with_failure();
        end
    endtask

    task automatic check_op(input string what, input mem_op_e exp, input mem_op_e act);
        if (exp !== act) begin
            $display("ERR %s %s: expected %s actual %s", test_name, what, exp.name(), act.name());
            halt_with_failure();
        end
    endtask

    task automatic check_ctr(input string what, input perf_ctr_t exp, input perf_ctr_t act);
        if (exp !== act) begin
            $display("ERR %s %s: expected %0d actual %0d", test_name, what, exp, act);
            halt_with_failure();
        end
    endtask

    task automatic issue(input mem_op_e op, input word_addr_t addr, input byteen_t be,
                         input word_t data);
        core_req_valid  <= 1'b1;
        core_req_op     <= op;
        core_req_addr   <= addr;
        core_req_byteen <= be;
        core_req_data   <= data;
        core_req_tag    <= next_tag;
        next_tag = next_tag + 1'b1;
        @(posedge clk);
        while (!core_req_ready) begin
            @(posedge clk);
        end
        core_req_valid <= 1'b0;
    endtask

    // Drain everything, then compare the counters
    task automatic wait_done();
        @(posedge clk);
        while (exp_rsp.size() != 0 || exp_mreq.size() != 0 || mem_req_valid
               || core_rsp_valid) begin
            @(posedge clk);
        end
        check_ctr("perf_reads", perf_ctr_t'(n_reads), perf_reads);
        check_ctr("perf_writes", perf_ctr_t'(n_writes), perf_writes);
        check_ctr("perf_read_misses", perf_ctr_t'(n_misses), perf_read_misses);
        check_ctr("perf_mem_stalls", perf_ctr_t'(n_stalls), perf_mem_stalls);
    endtask

    ////////////////////////////////////////
    // Monitors and models

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (!reset && mem_req_valid && !mem_req_ready) begin
            n_stalls++;
        end
    end

    always @(posedge clk) begin
        if (random_ready) begin
            core_rsp_ready <= (rand_bits(2) != 0);
            mem_req_ready  <= (rand_bits(2) != 0);
        end else begin
            core_rsp_ready <= 1'b1;
            mem_req_ready  <= 1'b1;
        end
    end

    // Predicts hits, misses and memory traffic in program order
    always @(posedge clk) begin : accept_monitor
        cache_tag_t ctag;
        index_t     idx;
        wsel_t      wsel;
        mreq_exp_t  e;
        rsp_exp_t   r;
        logic       hit;
        if (reset) begin
            for (int i = 0; i < `CACHE_NUM_LINES; i++) begin
                model_valid[i] = 1'b0;
            end
        end else if (core_req_valid && core_req_ready) begin
            {ctag, idx, wsel} = core_req_addr;
            e = '0;
            e.addr = {ctag, idx};
            e.wsel = wsel;
            if (core_req_op == OP_READ) begin
                n_reads++;
                hit = model_valid[idx] && (model_tag[idx] == ctag);
                if (!hit) begin
                    n_misses++;
                    model_valid[idx] = 1'b1;
                    model_tag[idx]   = ctag;
                    e.op = OP_READ;
                    exp_mreq.push_back(e);
                end
                r.tag   = core_req_tag;
                r.data  = ref_read(core_req_addr);
                r.hit   = hit;
                r.cycle = cycle;
                exp_rsp.push_back(r);
            end else begin
                n_writes++;
                shadow[core_req_addr] = merge_bytes(shadow[core_req_addr], core_req_data,
                                                    core_req_byteen);
                e.op   = OP_WRITE;
                e.be   = line_byteen_t'(core_req_byteen) << (int'(wsel) * 4);
                e.word = core_req_data;
                exp_mreq.push_back(e);
            end
        end
    end

    always @(posedge clk) begin
        if (!reset && core_rsp_valid) begin
            if (exp_rsp.size() == 0) begin
                abort_run("Core response arrived with no read outstanding");
            end
            if (!rsp_seen) begin
                rsp_seen = 1'b1;
                if (exp_rsp[0].hit && cycle != exp_rsp[0].cycle + 2) begin
                    abort_run("Read hit response did not come 2 cycles after acceptance");
                end
            end
            if (core_rsp_ready) begin
                check_tag("rsp tag", exp_rsp[0].tag, core_rsp_tag);
                check_word("rsp data", exp_rsp[0].data, core_rsp_data);
                void'(exp_rsp.pop_front());
                rsp_seen = 1'b0;
            end
        end
    end

    // Memory model writes on acceptance and answers reads in order after a delay
    always @(posedge clk) begin : memory_model
        mreq_exp_t  e;
        line_t      line;
        line_addr_t addr;
        if (reset) begin
            mem_rsp_valid <= 1'b0;
            rd_pending.delete();
        end else begin
            if (mem_rsp_valid && mem_rsp_ready) begin
                mem_rsp_valid <= 1'b0;
            end
            if (mem_req_valid && mem_req_ready) begin
                if (exp_mreq.size() == 0) begin
                    abort_run("Memory request that no core request explains");
                end
                e = exp_mreq.pop_front();
                check_op("mem op", e.op, mem_req_op);
                check_line_addr("mem addr", e.addr, mem_req_addr);
                check_byteen("mem byteen", e.be, mem_req_byteen);
                if (e.op == OP_WRITE) begin
                    check_word("mem write data", e.word,
                               mem_req_data[int'(e.wsel)*`CACHE_WORD_BITS +: `CACHE_WORD_BITS]);
                    for (int b = 0; b < 16; b++) begin
                        if (mem_req_byteen[b]) begin
                            mem_words[{mem_req_addr, 2'(b / 4)}][(b % 4)*8 +: 8] =
                                mem_req_data[b*8 +: 8];
                        end
                    end
                end else begin
                    rd_pending.push_back(mem_req_addr);
                    rsp_wait = int'(rand_bits(3));
                end
            end
            if (!mem_rsp_valid && rd_pending.size() != 0) begin
                if (rsp_wait == 0) begin
                    addr = rd_pending.pop_front();
                    for (int w = 0; w < `CACHE_LINE_WORDS; w++) begin
                        line[w*`CACHE_WORD_BITS +: `CACHE_WORD_BITS] = mem_words[{addr, 2'(w)}];
                    end
                    mem_rsp_data  <= line;
                    mem_rsp_valid <= 1'b1;
                end else begin
                    rsp_wait--;
                end
            end
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Watchdog timeout: the cache stopped making progress");
        halt_with_failure();
    end

    ////////////////////////////////////////
    // Stimulus

    initial begin
        logic [31:0] r;
        word_addr_t  addr;
        reset           <= 1'b1;
        core_req_valid  <= 1'b0;
        core_req_op     <= OP_READ;
        core_req_addr   <= '0;
        core_req_byteen <= '0;
        core_req_data   <= '0;
        core_req_tag    <= '0;
        core_rsp_ready  <= 1'b1;
        mem_req_ready   <= 1'b1;
        mem_rsp_valid   <= 1'b0;
        mem_rsp_data    <= '0;
        for (int a = 0; a < (1 << `CACHE_WORD_ADDR_BITS); a++) begin
            mem_words[a] = fill_pattern(word_addr_t'(a));
            shadow[a]    = fill_pattern(word_addr_t'(a));
        end
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        check_ctr("perf_reads after reset", '0, perf_reads);
        check_ctr("perf_writes after reset", '0, perf_writes);
        check_ctr("perf_read_misses after reset", '0, perf_read_misses);
        check_ctr("perf_mem_stalls after reset", '0, perf_mem_stalls);
        if (core_req_ready !== 1'b0 || core_rsp_valid !== 1'b0 || mem_req_valid !== 1'b0
            || mem_rsp_ready !== 1'b0) begin
            abort_run("A handshake output was not low right after reset");
        end

        // First touch of each line misses
        test_name = "flush";
        issue(OP_READ, 12'h000, '0, '0);
        issue(OP_READ, 12'h005, '0, '0);
        issue(OP_READ, 12'h009, '0, '0);
        wait_done();

        test_name = "read_hit";
        issue(OP_READ, 12'h000, '0, '0);
        issue(OP_READ, 12'h005, '0, '0);
        wait_done();

        test_name = "write_through";
        issue(OP_WRITE, 12'h001, 4'b0101, 32'ha5a5_5a5a);
        issue(OP_WRITE, 12'h400, 4'b1000, 32'h1234_5678);
        issue(OP_READ, 12'h001, '0, '0);
        issue(OP_READ, 12'h400, '0, '0);
        wait_done();

        // Four tags share four indices, so hits and conflict misses mix
        test_name = "random_mix";
        random_ready <= 1'b1;
        for (int i = 0; i < N_OPS; i++) begin
            r = rand_bits(6);
            addr = {4'd0, r[5:4], 2'd0, r[3:2], r[1:0]};
            if (rand_bits(1) == 32'd1) begin
                issue(OP_WRITE, addr, byteen_t'(rand_bits(4)), rand_bits(32));
            end else begin
                issue(OP_READ, addr, '0, '0);
            end
            if (rand_bits(2) == 32'd0) begin
                @(posedge clk);
            end
        end
        wait_done();

        if (dut0.chk0.fail_count != 0) begin
            abort_run("A checker assertion failed during the run");
        end else begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

/* all.f */
+incdir+.
cache_pkg.sv
mem_req_if.sv
flush_ctrl.sv
cache_tag_ram.sv
cache_data_ram.sv
mem_req_queue.sv
cache_bank.sv
perf_counters.sv
cache_top.sv
tb_cache_chk.sv
tb_cache.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP      = tb_cache
FILELIST = all.f
OBJ_DIR  = obj_dir
PASS_MSG = Simulation completed successfully

SOURCES  = $(shell grep -v '^+' $(FILELIST)) cache_macros.svh
BIN      = $(OBJ_DIR)/V$(TOP)

.PHONY: run clean

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

clean:
	rm -rf $(OBJ_DIR)
